// ==== Bender.yml ====
package:
  name: rv_exec_unit

sources:
  - rv_isa_pkg.sv
  - rv_alu_pkg.sv
  - rv_decode_if.sv
  - rv_instr_decoder.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_shift_timer.sv
  - rv_exec_fsm.sv
  - rv_exec_unit.sv
  - target: test
    files:
      - rv_exec_checker.sv
      - rv_exec_unit_sva.sv
      - tb_rv_exec_unit.sv

// ==== project.f ====
rv_isa_pkg.sv
rv_alu_pkg.sv
rv_decode_if.sv
rv_instr_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_shift_timer.sv
rv_exec_fsm.sv
rv_exec_unit.sv
rv_exec_checker.sv
rv_exec_unit_sva.sv
tb_rv_exec_unit.sv

// ==== rv_alu.sv ====
module rv_alu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        alu_start,
    input  logic                        shift_load,
    input  logic                        shift_step,
    input  logic [rv_alu_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_alu_pkg::XLEN-1:0] rs2_data,
    rv_decode_if.alu                    op,
    output logic [rv_alu_pkg::XLEN-1:0] result
);

    logic [rv_alu_pkg::XLEN-1:0]    opb;
    logic [rv_alu_pkg::XLEN-1:0]    calc;
    logic [rv_alu_pkg::XLEN-1:0]    res_q;
    logic [rv_alu_pkg::SHAMT_W-1:0] amt_q;

    assign opb = op.use_imm ? op.imm : rs2_data;

    // Single-cycle operations
    always_comb begin
        case (op.alu_op)
            rv_alu_pkg::SUB:  calc = rs1_data - opb;
            rv_alu_pkg::AND:  calc = rs1_data & opb;
            rv_alu_pkg::OR:   calc = rs1_data | opb;
            rv_alu_pkg::XOR:  calc = rs1_data ^ opb;
            rv_alu_pkg::SLT:  calc = {{(rv_alu_pkg::XLEN-1){1'b0}},
                                      $signed(rs1_data) < $signed(opb)};
            rv_alu_pkg::SLTU: calc = {{(rv_alu_pkg::XLEN-1){1'b0}}, rs1_data < opb};
            default:          calc = rs1_data + opb;
        endcase
    end

    ////////////////////
    // Result and shift register
    ////////////////////

    always_ff @(posedge clk) begin
        if (alu_start) begin
            res_q <= calc;
        end else if (shift_load) begin
            res_q <= rs1_data;
        end else if (shift_step && (amt_q != '0)) begin
            case (op.alu_op)
                rv_alu_pkg::SLL: res_q <= {res_q[rv_alu_pkg::XLEN-2:0], 1'b0};
                rv_alu_pkg::SRA: res_q <= {res_q[rv_alu_pkg::XLEN-1],
                                           res_q[rv_alu_pkg::XLEN-1:1]};
                default:         res_q <= {1'b0, res_q[rv_alu_pkg::XLEN-1:1]};
            endcase
        end
    end

    // Steps left to apply; surplus timer steps are ignored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            amt_q <= '0;
        end else if (shift_load) begin
            amt_q <= opb[rv_alu_pkg::SHAMT_W-1:0];
        end else if (shift_step && (amt_q != '0)) begin
            amt_q <= amt_q - 1'b1;
        end
    end

    assign result = res_q;

endmodule

// ==== rv_alu_pkg.sv ====
package rv_alu_pkg;

    ////////////////////
    // Datapath
    ////////////////////

    localparam int XLEN    = 32;

    // Five bits cover every shift of a 32-bit word
    localparam int SHAMT_W = 5;

    ////////////////////
    // ALU operations
    ////////////////////

    typedef enum logic [3:0] {
        // Arithmetic
        ADD,
        SUB,

        // Bitwise logic
        AND,
        OR,
        XOR,

        // Compares give 0 or 1
        SLT,
        SLTU,

        // Serial shifts
        SLL,
        SRL,
        SRA
    } alu_op_e;

endpackage

// ==== rv_decode_if.sv ====
interface rv_decode_if;

    // Register indices
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;

    // Operand select and operation
    logic [rv_alu_pkg::XLEN-1:0]       imm;
    logic                              use_imm;
    rv_alu_pkg::alu_op_e               alu_op;

    // Control for the state machine and shift timer
    logic [rv_alu_pkg::SHAMT_W-1:0]    shamt;
    logic                              is_shift;
    logic                              is_alu;

    modport decoder (
        output rs1, rs2, rd, imm, use_imm, alu_op, shamt, is_shift, is_alu
    );

    modport regfile (input rs1, rs2, rd);

    modport alu (input alu_op, imm, use_imm);

    modport ctrl (input is_alu, is_shift, shamt);

endinterface

// ==== rv_exec_checker.sv ====
module rv_exec_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic        busy,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output int          tests,
    output int          errors
);

    localparam int BASE_LATENCY = 3;
    localparam int MAX_LATENCY  = 40;
    localparam int NON_ALU_BUSY = 2;

    logic [31:0] model [32];
    logic [31:0] pend_instr;
    logic [31:0] exp_data;
    logic [4:0]  exp_rd;
    logic        pending;
    logic        pend_alu;
    logic        ok;
    int          exp_lat;
    int          age;

    // Expected result from the RV32I rules
    function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] rs2_val);
        logic [31:0] b;
        logic [4:0]  sh;
        logic        sub;
        b   = (w[6:0] == rv_isa_pkg::OPCODE_OP_IMM) ? {{20{w[31]}}, w[31:20]} : rs2_val;
        sh  = b[4:0];
        sub = w[30] && (w[6:0] == rv_isa_pkg::OPCODE_OP);
        case (w[14:12])
            3'b000:  ref_result = sub ? a - b : a + b;
            3'b001:  ref_result = a << sh;
            3'b010:  ref_result = {31'b0, $signed(a) < $signed(b)};
            3'b011:  ref_result = {31'b0, a < b};
            3'b100:  ref_result = a ^ b;
            3'b110:  ref_result = a | b;
            3'b111:  ref_result = a & b;
            default: begin
                if (w[30]) ref_result = $signed(a) >>> sh;
                else ref_result = a >> sh;
            end
        endcase
    endfunction

    initial begin
        tests   = 0;
        errors  = 0;
        pending = 1'b0;
    end

    ////////////////////
    // Sampling at the falling edge
    ////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            pending = 1'b0;
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
        end else begin
            if (pending) begin
                age++;
                if (wb_valid) begin
                    ok = pend_alu;
                    if (!pend_alu) begin
                        $display("non-ALU instruction %h gave a write-back at time %0t",
                                 pend_instr, $time);
                    end
                    if (pend_alu && wb_rd !== exp_rd) begin
                        ok = 1'b0;
                        $display("mismatch at time %0t: wb_rd expected %0d actual %0d",
                                 $time, exp_rd, wb_rd);
                    end
                    if (pend_alu && wb_data !== exp_data) begin
                        ok = 1'b0;
                        $display("mismatch at time %0t: wb_data expected %h actual %h",
                                 $time, exp_data, wb_data);
                    end
                    if (exp_lat >= 0 ? age != exp_lat : age > BASE_LATENCY + 31) begin
                        ok = 1'b0;
                        $display("write-back of %h came %0d cycles after acceptance",
                                 pend_instr, age);
                    end
                    // x0 stays zero in the model as well
                    if (pend_alu && exp_rd != 5'd0) model[exp_rd] = exp_data;
                    tests++;
                    if (!ok) errors++;
                    $display("test %0d: %h -> x%0d = %h %s", tests, pend_instr, exp_rd,
                             exp_data, ok ? "ok" : "error");
                    pending = 1'b0;
                end else if (!pend_alu && busy === 1'b0) begin
                    tests++;
                    ok = (age == NON_ALU_BUSY + 1);
                    if (!ok) begin
                        errors++;
                        $display("non-ALU instruction %h kept busy high for %0d cycles, not %0d",
                                 pend_instr, age - 1, NON_ALU_BUSY);
                    end
                    $display("test %0d: %h retired with no write-back %s", tests, pend_instr,
                             ok ? "ok" : "error");
                    pending = 1'b0;
                end else if (busy !== 1'b1) begin
                    tests++;
                    errors++;
                    $display("mismatch at time %0t: busy expected 1 actual %b", $time, busy);
                    $display("test %0d: %h lost busy before its write-back error",
                             tests, pend_instr);
                    pending = 1'b0;
                end else if (age > MAX_LATENCY) begin
                    tests++;
                    errors++;
                    $display("instruction %h did not finish within %0d cycles",
                             pend_instr, MAX_LATENCY);
                    pending = 1'b0;
                end
            end else begin
                if (wb_valid) begin
                    errors++;
                    $display("write-back to x%0d with no instruction in flight at time %0t",
                             wb_rd, $time);
                end
                if (busy !== 1'b0) begin
                    errors++;
                    $display("mismatch at time %0t: busy expected 0 actual %b", $time, busy);
                end
            end

            // Same condition the DUT uses at the next rising edge
            if (instr_valid && !busy) begin
                pending    = 1'b1;
                pend_instr = instr;
                pend_alu   = (instr[6:0] == rv_isa_pkg::OPCODE_OP) ||
                             (instr[6:0] == rv_isa_pkg::OPCODE_OP_IMM);
                exp_rd     = instr[11:7];
                exp_data   = ref_result(instr, model[instr[19:15]], model[instr[24:20]]);
                age        = 0;
                // Register shifts have no fixed latency
                if (instr[13:12] != 2'b01) begin
                    exp_lat = BASE_LATENCY;
                end else if (instr[6:0] == rv_isa_pkg::OPCODE_OP_IMM) begin
                    exp_lat = BASE_LATENCY + int'(instr[24:20]);
                end else begin
                    exp_lat = -1;
                end
            end
        end
    end

endmodule

// ==== rv_exec_fsm.sv ====
module rv_exec_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  logic       shift_done,
    rv_decode_if.ctrl  ctrl,
    output logic       load_instr,
    output logic       alu_start,
    output logic       shift_load,
    output logic       wb_en,
    output logic       busy
);

    typedef enum logic [2:0] {IDLE, DECODE, EXEC, SHIFT, WRITE} state_e;

    state_e state_q;
    state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (instr_valid) state_d = DECODE;
            // Non-ALU opcodes skip execution and retire silently
            DECODE:  state_d = !ctrl.is_alu ? WRITE : (ctrl.is_shift ? SHIFT : EXEC);
            EXEC:    state_d = WRITE;
            SHIFT:   if (shift_done) state_d = WRITE;
            WRITE:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    ////////////////////
    // Datapath strobes
    ////////////////////

    assign load_instr = (state_q == IDLE) && instr_valid;
    assign shift_load = (state_q == DECODE) && ctrl.is_alu && ctrl.is_shift;
    assign alu_start  = (state_q == EXEC);
    assign wb_en      = (state_q == WRITE) && ctrl.is_alu;
    assign busy       = (state_q != IDLE);

endmodule

// ==== rv_exec_unit.sv ====
module rv_exec_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    output logic                              busy,
    output logic                              wb_valid,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_alu_pkg::XLEN-1:0]       wb_data
);

    logic                        load_instr;
    logic                        alu_start;
    logic                        shift_load;
    logic                        shift_step;
    logic                        shift_done;
    logic                        wb_en;
    logic [rv_alu_pkg::XLEN-1:0] rs1_data;
    logic [rv_alu_pkg::XLEN-1:0] rs2_data;
    logic [rv_alu_pkg::XLEN-1:0] alu_result;

    rv_decode_if dec_if ();

    ////////////////////
    // Control
    ////////////////////

    rv_exec_fsm u_fsm (
        .clk, .rst_n, .instr_valid, .shift_done, .ctrl(dec_if.ctrl),
        .load_instr, .alu_start, .shift_load, .wb_en, .busy
    );

    rv_shift_timer u_timer (
        .clk, .rst_n, .shift_load, .ctrl(dec_if.ctrl), .shift_step, .shift_done
    );

    ////////////////////
    // Datapath
    ////////////////////

    rv_instr_decoder u_decoder (.clk, .rst_n, .load_instr, .instr, .dec(dec_if.decoder));

    rv_regfile u_regfile (
        .clk, .rst_n, .wb_en, .wb_data(alu_result), .rf(dec_if.regfile), .rs1_data, .rs2_data
    );

    rv_alu u_alu (
        .clk, .rst_n, .alu_start, .shift_load, .shift_step, .rs1_data, .rs2_data,
        .op(dec_if.alu), .result(alu_result)
    );

    // Write-back report
    assign wb_valid = wb_en;
    assign wb_rd    = dec_if.rd;
    assign wb_data  = alu_result;

endmodule

// ==== rv_exec_unit_sva.sv ====
module rv_exec_unit_sva (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic wb_valid
);

    int fail_count = 0;

    // Write-back strobe lasts one cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |=> !wb_valid)
        else begin
            $error("wb_valid high for two cycles in a row");
            fail_count++;
        end

    // Results appear only with an instruction in flight
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> busy)
        else begin
            $error("wb_valid high while busy is low");
            fail_count++;
        end

    // FSM back in idle after a reset edge
    assert property (@(posedge clk) !rst_n |=> !busy)
        else begin
            $error("busy high in the cycle after reset");
            fail_count++;
        end

endmodule

bind rv_exec_unit rv_exec_unit_sva u_sva (.clk, .rst_n, .busy, .wb_valid);

// ==== rv_instr_decoder.sv ====
module rv_instr_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_instr,
    input  logic [31:0]        instr,
    rv_decode_if.decoder       dec
);

    rv_isa_pkg::instr_u  word_q;
    rv_alu_pkg::alu_op_e op;
    logic                is_op;
    logic                is_op_imm;
    logic                is_alu;
    logic                alt;
    logic                is_shift;
    logic                shift_imm;

    // Instruction register, loaded at the accepting edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (load_instr) begin
            word_q <= instr;
        end
    end

    assign is_op     = (word_q.r.opcode == rv_isa_pkg::OPCODE_OP);
    assign is_op_imm = (word_q.r.opcode == rv_isa_pkg::OPCODE_OP_IMM);
    assign is_alu    = is_op || is_op_imm;
    assign alt       = word_q[rv_isa_pkg::FUNCT7_ALT_BIT];

    ////////////////////
    // Operation select
    ////////////////////

    always_comb begin
        op = rv_alu_pkg::ADD;
        if (is_alu) begin
            case (word_q.r.funct3)
                // SUB exists only in the register form
                rv_isa_pkg::FUNCT3_ADD:  op = (is_op && alt) ? rv_alu_pkg::SUB
                                                             : rv_alu_pkg::ADD;
                rv_isa_pkg::FUNCT3_SLL:  op = rv_alu_pkg::SLL;
                rv_isa_pkg::FUNCT3_SLT:  op = rv_alu_pkg::SLT;
                rv_isa_pkg::FUNCT3_SLTU: op = rv_alu_pkg::SLTU;
                rv_isa_pkg::FUNCT3_XOR:  op = rv_alu_pkg::XOR;
                rv_isa_pkg::FUNCT3_SRL:  op = alt ? rv_alu_pkg::SRA : rv_alu_pkg::SRL;
                rv_isa_pkg::FUNCT3_OR:   op = rv_alu_pkg::OR;
                rv_isa_pkg::FUNCT3_AND:  op = rv_alu_pkg::AND;
                default:                 op = rv_alu_pkg::ADD;
            endcase
        end
    end

    assign is_shift  = (op == rv_alu_pkg::SLL) || (op == rv_alu_pkg::SRL) ||
                       (op == rv_alu_pkg::SRA);
    assign shift_imm = is_op_imm && is_shift;

    ////////////////////
    // Decoded fields
    ////////////////////

    assign dec.rs1      = word_q.r.rs1;
    assign dec.rs2      = word_q.r.rs2;
    assign dec.rd       = word_q.r.rd;
    assign dec.alu_op   = op;
    assign dec.use_imm  = is_op_imm;
    assign dec.is_alu   = is_alu;
    assign dec.is_shift = is_shift;

    // Shift-immediates drop the funct7 bits, the rest sign-extend
    assign dec.imm = shift_imm
        ? {{(rv_alu_pkg::XLEN - rv_alu_pkg::SHAMT_W){1'b0}},
           word_q.i.imm12[rv_alu_pkg::SHAMT_W-1:0]}
        : {{(rv_alu_pkg::XLEN - 12){word_q.i.imm12[11]}}, word_q.i.imm12};

    // Immediate amount sits in the rs2 slot; register amount is only
    // known from rs2 data, so the timer runs the full range for those
    assign dec.shamt = is_op_imm ? word_q.r.rs2 : '1;

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Instruction bit 30, the alternate funct7 bit
    localparam int FUNCT7_ALT_BIT = 30;

    ////////////////////
    // Opcodes and funct3
    ////////////////////

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SRL  = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    ////////////////////
    // Instruction formats
    ////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    // One word read as register view or immediate view
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// ==== rv_regfile.sv ====
module rv_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_en,
    input  logic [rv_alu_pkg::XLEN-1:0] wb_data,
    rv_decode_if.regfile                rf,
    output logic [rv_alu_pkg::XLEN-1:0] rs1_data,
    output logic [rv_alu_pkg::XLEN-1:0] rs2_data
);

    logic [rv_alu_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];

    ////////////////////
    // Write port
    ////////////////////

    // x0 is never written, so it holds the zero from reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (rf.rd != '0)) begin
            regs[rf.rd] <= wb_data;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Asynchronous reads
    assign rs1_data = regs[rf.rs1];
    assign rs2_data = regs[rf.rs2];

endmodule

// ==== rv_shift_timer.sv ====
module rv_shift_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       shift_load,
    rv_decode_if.ctrl  ctrl,
    output logic       shift_step,
    output logic       shift_done
);

    logic [rv_alu_pkg::SHAMT_W-1:0] count_q;

    // Countdown, one step per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (shift_load) begin
            count_q <= ctrl.shamt;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Zero amount is done at once
    assign shift_step = (count_q != '0);
    assign shift_done = (count_q == '0);

endmodule

// ==== tb_rv_exec_unit.sv ====
module tb_rv_exec_unit;

    localparam int SEED         = 32'hbb93;
    localparam int NUM_RANDOM   = 200;
    localparam int BUSY_TIMEOUT = 50;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        busy;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        stuck;
    int          tests;
    int          errors;
    int          issued;
    int          total;

    rv_exec_unit dut (
        .clk, .rst_n, .instr_valid, .instr, .busy, .wb_valid, .wb_rd, .wb_data
    );

    rv_exec_checker u_checker (
        .clk, .rst_n, .instr_valid, .instr, .busy, .wb_valid, .wb_rd, .wb_data,
        .tests, .errors
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // Returns a little after a rising edge once busy is low
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && !stuck && n < BUSY_TIMEOUT) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (busy !== 1'b0 && !stuck) begin
            $display("busy stayed high for %0d cycles", BUSY_TIMEOUT);
            stuck = 1'b1;
        end
    endtask

    task automatic issue(input logic [31:0] w);
        wait_idle();
        if (!stuck) begin
            instr_valid = 1'b1;
            instr       = w;
            @(posedge clk);
            #10;
            instr_valid = 1'b0;
            issued++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;

        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        stuck       = 1'b0;
        issued      = 0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Random start value in every register
        for (int k = 1; k < 32; k++) begin
            r = $urandom;
            issue(i_type(r[11:0], 5'd0, 3'b000, k[4:0]));
        end

        ////////////////////
        // Random mix
        ////////////////////

        repeat (NUM_RANDOM) begin
            r  = $urandom;
            f3 = r[14:12];
            // Bit 30 only where it picks SUB or SRA
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00;
            case (r[2:0])
                3'd0, 3'd1, 3'd2: issue(r_type(f7, r[24:20], r[19:15], f3, r[11:7]));
                3'd7: begin
                    // Load, store, branch, jal, jalr, lui, auipc
                    case (r[5:3])
                        3'd0:    opc = 7'b0000011;
                        3'd1:    opc = 7'b0100011;
                        3'd2:    opc = 7'b1100011;
                        3'd3:    opc = 7'b1101111;
                        3'd4:    opc = 7'b1100111;
                        3'd5:    opc = 7'b0110111;
                        default: opc = 7'b0010111;
                    endcase
                    issue({r[31:7], opc});
                end
                default: begin
                    if (f3[1:0] == 2'b01) issue(i_type({f7, r[24:20]}, r[19:15], f3, r[11:7]));
                    else issue(i_type(r[31:20], r[19:15], f3, r[11:7]));
                end
            endcase
        end

        // Sign boundaries for SLTI and SLTIU
        issue(i_type(12'hfff, 5'd0, 3'b000, 5'd1));
        issue(i_type(12'h001, 5'd1, 3'b101, 5'd2));
        issue(i_type(12'h001, 5'd2, 3'b000, 5'd3));
        issue(i_type(12'hfff, 5'd3, 3'b010, 5'd4));
        issue(i_type(12'h800, 5'd2, 3'b010, 5'd5));
        issue(i_type(12'hfff, 5'd1, 3'b011, 5'd6));
        issue(i_type(12'hfff, 5'd2, 3'b011, 5'd7));
        issue(i_type(12'h7ff, 5'd3, 3'b011, 5'd8));

        ////////////////////
        // Shift sweep
        ////////////////////

        for (int a = 0; a < 32; a++) begin
            r = $urandom;
            issue(i_type({7'h00, a[4:0]}, r[19:15], 3'b001, r[11:7]));
            issue(i_type({7'h00, a[4:0]}, r[19:15], 3'b101, r[11:7]));
            issue(i_type({7'h20, a[4:0]}, r[19:15], 3'b101, r[11:7]));
            // x9 gets junk above the low five bits
            issue(i_type({r[31:25], a[4:0]}, 5'd0, 3'b000, 5'd9));
            issue(r_type(7'h00, 5'd9, r[24:20], 3'b001, {2'b11, r[9:7]}));
            issue(r_type(7'h00, 5'd9, r[24:20], 3'b101, {2'b11, r[9:7]}));
            issue(r_type(7'h20, 5'd9, r[24:20], 3'b101, {2'b11, r[9:7]}));
        end

        // Write x0 and read it back
        issue(i_type(12'h123, 5'd5, 3'b000, 5'd0));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd10));

        // Strobe while busy must be dropped
        repeat (3) begin
            issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd11));
            instr_valid = 1'b1;
            instr       = i_type(12'h555, 5'd0, 3'b000, 5'd11);
            @(posedge clk);
            #10;
            instr_valid = 1'b0;
        end

        wait_idle();
        repeat (2) @(posedge clk);
        total = errors + dut.u_sva.fail_count;
        if (stuck) total++;
        if (tests != issued) begin
            $display("checker finished %0d tests but %0d instructions were issued",
                     tests, issued);
            total++;
        end
        $display("tests %0d, errors %0d", tests, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
